/* Bender.yml */
package:
  name: multiplier_pipeline

sources:
  # Package first, then the leaf blocks, then the top level.
  - design/mul_pkg.sv
  - design/delay_line.sv
  - design/word_multiplier.sv
  - design/thread_config_store.sv
  - design/multiplier_pipeline.sv

  # Simulation only.
  - target: test
    files:
      - verif/multiplier_pipeline_tb.sv

# Top levels:
#   RTL:       multiplier_pipeline
#   Testbench: multiplier_pipeline_tb
# Run from the project root so the stimulus file path resolves.

/* design/delay_line.sv */
/*
 * Fixed-depth delay line.
 * A chain of DEPTH registers of WIDTH bits, cleared on reset.
 */

`timescale 1ns/1ps

module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    // Tap 0 is the input, tap DEPTH is the last register.
    logic [WIDTH-1:0] tap [DEPTH+1];

    assign tap[0] = data_in;

    // One register per stage.
    for (genvar i = 0; i < DEPTH; i++) begin : g_stage
        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                tap[i+1] <= '0;
            end else begin
                tap[i+1] <= tap[i];
            end
        end
    end

    assign data_out = tap[DEPTH];

endmodule

/* design/mul_pkg.sv */
/*
 * Shared definitions for the barrel-scheduled multiplier accelerator.
 * Holds the word and thread constants, the signedness mode and the
 * operand and result bundles that travel down the pipeline.
 */

package mul_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------

    // Operand and result word width.
    localparam int WORD_WIDTH   = 32;

    // Hardware threads served by the barrel schedule.
    localparam int THREAD_COUNT = 8;

    // Bits needed to name one thread.
    localparam int THREAD_WIDTH = 3;

    // ------------------------------
    // Types
    // ------------------------------

    // Index of a thread slot.
    typedef logic [THREAD_WIDTH-1:0] thread_id_t;

    // Multiplication mode, one per thread.
    // Reset value is unsigned.
    typedef enum logic {
        SIGN_UNSIGNED = 1'b0,
        SIGN_SIGNED   = 1'b1
    } sign_mode_e;

    // Everything the multiplier needs for one thread's product.
    typedef struct packed {
        logic [WORD_WIDTH-1:0] a;
        logic [WORD_WIDTH-1:0] b;
        sign_mode_e            sign_mode;
    } mul_operands_t;

    // Full double-width product, split into words.
    typedef struct packed {
        logic [WORD_WIDTH-1:0] high;
        logic [WORD_WIDTH-1:0] low;
    } mul_result_t;

endpackage

/* design/multiplier_pipeline.sv */
/*
 * Barrel-scheduled multiplier accelerator, top level.
 * Latches operands per slot, delays them to the multiplier, then delays
 * the product so each thread reads its result eight cycles later.
 */

`timescale 1ns/1ps

module multiplier_pipeline #(
    parameter int unsigned                  CONFIG_ADDR_WIDTH = 4,
    parameter logic [CONFIG_ADDR_WIDTH-1:0] CONFIG_ADDR       = '0
) (
    input  logic                           clock,
    input  logic                           rst_n,

    input  logic [CONFIG_ADDR_WIDTH-1:0]   config_addr,
    input  logic                           config_signed,
    input  logic                           config_wren,

    input  logic [mul_pkg::WORD_WIDTH-1:0] a,
    input  logic                           a_wren,
    input  logic [mul_pkg::WORD_WIDTH-1:0] b,
    input  logic                           b_wren,

    output logic [mul_pkg::WORD_WIDTH-1:0] result_low,
    output logic [mul_pkg::WORD_WIDTH-1:0] result_high
);

    import mul_pkg::*;

    // ------------------------------
    // Pipeline depths
    // ------------------------------

    // Latch (1) + input delay (3) + output delay (4) = one full round.
    localparam int INPUT_DELAY_DEPTH  = THREAD_COUNT / 2 - 1;
    localparam int INPUT_DELAY_WIDTH  = $bits(mul_operands_t);
    localparam int OUTPUT_DELAY_DEPTH = THREAD_COUNT / 2;
    localparam int OUTPUT_DELAY_WIDTH = $bits(mul_result_t);

    // ------------------------------
    // Per-thread signedness
    // ------------------------------

    // Mode of the thread in the current slot.
    sign_mode_e sign_mode;

    thread_config_store #(
        .CONFIG_ADDR_WIDTH (CONFIG_ADDR_WIDTH),
        .CONFIG_ADDR       (CONFIG_ADDR)
    ) config_store (
        .clock         (clock),
        .rst_n         (rst_n),
        .config_addr   (config_addr),
        .config_signed (config_signed),
        .config_wren   (config_wren),
        .sign_mode     (sign_mode)
    );

    // ------------------------------
    // Operand latches
    // ------------------------------

    // Each operand loads only on its own strobe.
    // A thread can keep one operand constant and update the other.
    logic [WORD_WIDTH-1:0] a_latched;
    logic [WORD_WIDTH-1:0] b_latched;

    // The mode is read during the write slot, so it is registered
    // with the operands to stay aligned with them.
    sign_mode_e            sign_mode_latched;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            a_latched         <= '0;
            b_latched         <= '0;
            sign_mode_latched <= SIGN_UNSIGNED;
        end else begin
            if (a_wren) begin
                a_latched <= a;
            end
            if (b_wren) begin
                b_latched <= b;
            end
            sign_mode_latched <= sign_mode;
        end
    end

    // ------------------------------
    // Input delay and multiply
    // ------------------------------

    mul_operands_t operands_in;
    mul_operands_t operands_delayed;
    mul_result_t   product;

    assign operands_in = '{a: a_latched, b: b_latched, sign_mode: sign_mode_latched};

    // Stages ahead of the multiplier, free for retiming into it.
    delay_line #(
        .DEPTH (INPUT_DELAY_DEPTH),
        .WIDTH (INPUT_DELAY_WIDTH)
    ) input_delay (
        .clock    (clock),
        .rst_n    (rst_n),
        .data_in  (operands_in),
        .data_out (operands_delayed)
    );

    word_multiplier multiplier (
        .operands (operands_delayed),
        .result   (product)
    );

    // ------------------------------
    // Output delay
    // ------------------------------

    mul_result_t result_delayed;

    // Trailing stages; the result lands in the thread's next slot.
    delay_line #(
        .DEPTH (OUTPUT_DELAY_DEPTH),
        .WIDTH (OUTPUT_DELAY_WIDTH)
    ) output_delay (
        .clock    (clock),
        .rst_n    (rst_n),
        .data_in  (product),
        .data_out (result_delayed)
    );

    assign result_high = result_delayed.high;
    assign result_low  = result_delayed.low;

endmodule

/* design/thread_config_store.sv */
/*
 * Thread configuration store.
 * Rotates the barrel slot counter and keeps one signedness bit per
 * thread, written through a single memory-mapped configuration word.
 */

`timescale 1ns/1ps

module thread_config_store #(
    parameter int unsigned                  CONFIG_ADDR_WIDTH = 4,
    parameter logic [CONFIG_ADDR_WIDTH-1:0] CONFIG_ADDR       = '0
) (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic [CONFIG_ADDR_WIDTH-1:0] config_addr,
    input  logic                         config_signed,
    input  logic                         config_wren,
    output mul_pkg::sign_mode_e          sign_mode
);

    import mul_pkg::*;

    // ------------------------------
    // Thread slot counter
    // ------------------------------

    // Thread owning the current cycle.
    thread_id_t slot;

    // One step per clock, 0 through 7 then back to 0.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (slot == thread_id_t'(THREAD_COUNT - 1)) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // ------------------------------
    // Configuration decode
    // ------------------------------

    // A write lands only on the exact configuration address.
    logic config_hit;

    assign config_hit = config_wren && (config_addr == CONFIG_ADDR);

    // ------------------------------
    // Per-thread mode table
    // ------------------------------

    sign_mode_e mode_table [THREAD_COUNT];

    // Only the LSB of the config word matters.
    // The write goes to the thread whose slot it arrived in.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < THREAD_COUNT; i++) begin
                mode_table[i] <= SIGN_UNSIGNED;
            end
        end else if (config_hit) begin
            mode_table[slot] <= sign_mode_e'(config_signed);
        end
    end

    // Combinational read for the current slot.
    // A write in this same cycle is seen on the thread's next visit.
    assign sign_mode = mode_table[slot];

endmodule

/* design/word_multiplier.sv */
/*
 * Full-word multiplier.
 * Combinational 32 x 32 product, signed or unsigned per the operand
 * bundle, returned as high and low words.
 */

`timescale 1ns/1ps

module word_multiplier (
    input  mul_pkg::mul_operands_t operands,
    output mul_pkg::mul_result_t   result
);

    import mul_pkg::*;

    // ------------------------------
    // Operand extension
    // ------------------------------

    // One extra bit per operand lets a single signed multiply cover
    // both modes: sign-extend when signed, zero-extend when unsigned.
    logic                          is_signed;
    logic signed [WORD_WIDTH:0]    a_ext;
    logic signed [WORD_WIDTH:0]    b_ext;

    // Product of the extended operands, 2 bits wider than needed.
    logic signed [2*WORD_WIDTH+1:0] product;

    assign is_signed = (operands.sign_mode == SIGN_SIGNED);

    always_comb begin
        a_ext = {is_signed & operands.a[WORD_WIDTH-1], operands.a};
        b_ext = {is_signed & operands.b[WORD_WIDTH-1], operands.b};
    end

    // ------------------------------
    // Multiply and split
    // ------------------------------

    // Behavioral multiply, left to synthesis to map onto DSP blocks.
    assign product = a_ext * b_ext;

    // The low 64 bits are the full product in either mode.
    always_comb begin
        result.high = product[2*WORD_WIDTH-1:WORD_WIDTH];
        result.low  = product[WORD_WIDTH-1:0];
    end

endmodule

/* files.f */
design/mul_pkg.sv
design/delay_line.sv
design/word_multiplier.sv
design/thread_config_store.sv
design/multiplier_pipeline.sv
verif/multiplier_pipeline_tb.sv

/* verif/multiplier_pipeline_tb.sv */
/*
 * Testbench for the barrel-scheduled multiplier accelerator.
 * Replays the slot stimulus file and checks each thread's product
 * one full round of slots after its operand write.
 */

`timescale 1ns/1ps

module multiplier_pipeline_tb;

    import mul_pkg::*;

    // ------------------------------
    // Constants
    // ------------------------------

    localparam int CLOCK_PERIOD_NS = 8;
    // A product shows up one full round of slots after the write.
    localparam int LATENCY         = 8;
    localparam int MAX_ENTRIES     = 128;
    localparam int RESET_TIMEOUT   = 20;

    // Operation codes of the stimulus file.
    localparam logic [3:0] OP_IDLE            = 4'd0;
    localparam logic [3:0] OP_WRITE_A         = 4'd1;
    localparam logic [3:0] OP_WRITE_B         = 4'd2;
    localparam logic [3:0] OP_WRITE_BOTH      = 4'd3;
    localparam logic [3:0] OP_CONFIGURE       = 4'd4;
    localparam logic [3:0] OP_SECTION_FREE    = 4'd5;
    localparam logic [3:0] OP_SECTION_ALIGNED = 4'd6;

    // ------------------------------
    // DUT signals
    // ------------------------------

    logic                  clock;
    logic                  rst_n;
    logic [3:0]            config_addr;
    logic                  config_signed;
    logic                  config_wren;
    logic [WORD_WIDTH-1:0] a;
    logic                  a_wren;
    logic [WORD_WIDTH-1:0] b;
    logic                  b_wren;
    logic [WORD_WIDTH-1:0] result_low;
    logic [WORD_WIDTH-1:0] result_high;

    multiplier_pipeline #(
        .CONFIG_ADDR_WIDTH (4),
        .CONFIG_ADDR       (4'h0)
    ) multiplier_pipeline_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .config_addr   (config_addr),
        .config_signed (config_signed),
        .config_wren   (config_wren),
        .a             (a),
        .a_wren        (a_wren),
        .b             (b),
        .b_wren        (b_wren),
        .result_low    (result_low),
        .result_high   (result_high)
    );

    // ------------------------------
    // Stimulus table and scoreboard
    // ------------------------------

    logic [3:0]            op_mem   [MAX_ENTRIES];
    logic [WORD_WIDTH-1:0] a_mem    [MAX_ENTRIES];
    logic [WORD_WIDTH-1:0] b_mem    [MAX_ENTRIES];
    logic [3:0]            addr_mem [MAX_ENTRIES];
    logic                  sgn_mem  [MAX_ENTRIES];
    logic                  chk_mem  [MAX_ENTRIES];
    mul_result_t           exp_mem  [MAX_ENTRIES];
    int                    line_mem [MAX_ENTRIES];
    int                    entry_count;

    // One entry per driven slot, oldest first.
    mul_result_t exp_q  [$];
    logic        chk_q  [$];
    string       name_q [$];

    integer seed;
    int     slot_index;
    int     section;

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD_NS / 2) clock = ~clock;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_result(input string name, input mul_result_t expected,
                                input mul_result_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s: expected %h_%h, actual %h_%h",
                name, expected.high, expected.low, actual.high, actual.low));
        end
    endtask

    // Data lines hold eight hex fields; comment and blank lines do not parse.
    task automatic load_stimulus();
        int               fd;
        int               count;
        int               line_no;
        logic [8*160-1:0] line_buf;
        logic [31:0]      f_op, f_a, f_b, f_addr, f_sgn, f_chk, f_high, f_low;
        fd = $fopen("verif/multiplier_stim.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open the stimulus file verif/multiplier_stim.txt.");
        end
        entry_count = 0;
        line_no     = 0;
        while (!$feof(fd) && entry_count < MAX_ENTRIES) begin
            line_buf = '0;
            count    = $fgets(line_buf, fd);
            line_no++;
            count = $sscanf(line_buf, "%h %h %h %h %h %h %h %h",
                f_op, f_a, f_b, f_addr, f_sgn, f_chk, f_high, f_low);
            if (count == 8) begin
                op_mem[entry_count]       = f_op[3:0];
                a_mem[entry_count]        = f_a;
                b_mem[entry_count]        = f_b;
                addr_mem[entry_count]     = f_addr[3:0];
                sgn_mem[entry_count]      = f_sgn[0];
                chk_mem[entry_count]      = f_chk[0];
                exp_mem[entry_count].high = f_high;
                exp_mem[entry_count].low  = f_low;
                line_mem[entry_count]     = line_no;
                entry_count++;
            end
        end
        $fclose(fd);
        if (entry_count == 0) begin
            stop_on_error("The stimulus file holds no usable lines.");
        end
    endtask

    // Drives one slot, then compares the slot issued one round earlier.
    task automatic run_slot(input logic [3:0] op, input logic [WORD_WIDTH-1:0] a_val,
                            input logic [WORD_WIDTH-1:0] b_val, input logic [3:0] addr,
                            input logic sgn, input logic do_check,
                            input mul_result_t expected, input string name);
        mul_result_t actual;
        mul_result_t due_expected;
        logic        due_check;
        string       due_name;
        @(posedge clock);
        a             <= a_val;
        b             <= b_val;
        a_wren        <= (op == OP_WRITE_A) || (op == OP_WRITE_BOTH);
        b_wren        <= (op == OP_WRITE_B) || (op == OP_WRITE_BOTH);
        config_addr   <= addr;
        config_signed <= sgn;
        config_wren   <= (op == OP_CONFIGURE);
        // The slot counter moves on at every edge.
        slot_index = (slot_index + 1) % THREAD_COUNT;
        exp_q.push_back(expected);
        chk_q.push_back(do_check);
        name_q.push_back(name);
        // Outputs are settled by the falling edge.
        @(negedge clock);
        if (exp_q.size() > LATENCY) begin
            due_expected = exp_q.pop_front();
            due_check    = chk_q.pop_front();
            due_name     = name_q.pop_front();
            actual.high  = result_high;
            actual.low   = result_low;
            if (due_check) begin
                check_result(due_name, due_expected, actual);
            end
        end
    endtask

    task automatic idle_slot();
        run_slot(OP_IDLE, '0, '0, '0, 1'b0, 1'b0, '0, "idle");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int          wait_cycles;
        int          gap;
        logic [31:0] gap_roll;
        mul_result_t actual;
        string       name;
        seed          = 32'h0204_cb8c;
        section       = 0;
        slot_index    = 0;
        rst_n         = 1'b0;
        config_addr   = '0;
        config_signed = 1'b0;
        config_wren   = 1'b0;
        a             = '0;
        a_wren        = 1'b0;
        b             = '0;
        b_wren        = 1'b0;

        load_stimulus();

        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        // Thread 0 owns the cycle right after release.
        wait_cycles = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clock);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                stop_on_error("Reset did not release within the timeout.");
            end
        end

        // Cleared pipeline reads zero.
        actual.high = result_high;
        actual.low  = result_low;
        check_result("reset outputs", '0, actual);

        for (int i = 0; i < entry_count; i++) begin
            if (op_mem[i] == OP_SECTION_FREE) begin
                section++;
                // Slot identity does not matter here, so a random gap is harmless.
                gap_roll = $random(seed);
                if (gap_roll[0]) begin
                    gap = int'(gap_roll[2:1]) + 1;
                    repeat (gap) idle_slot();
                end
            end else if (op_mem[i] == OP_SECTION_ALIGNED) begin
                section++;
                // Next driven slot must belong to thread 0.
                while ((slot_index + 1) % THREAD_COUNT != 0) begin
                    idle_slot();
                end
            end else begin
                name = $sformatf("section %0d line %0d", section, line_mem[i]);
                run_slot(op_mem[i], a_mem[i], b_mem[i], addr_mem[i], sgn_mem[i],
                         chk_mem[i], exp_mem[i], name);
            end
        end

        // One more round flushes the last products.
        repeat (LATENCY) idle_slot();

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verif/multiplier_stim.txt */
# Columns: op a b cfg_addr cfg_signed check exp_high exp_low, all hex.
# op: 0 idle, 1 write A, 2 write B, 3 write both, 4 configure,
#     5 section start with idle gaps, 6 section start aligned to slot 0.
# check 0 marks a slot whose result is not compared.
# Unsigned products from reset.
5 00000000 00000000 0 0 0 00000000 00000000
3 00000003 00000005 0 0 1 00000000 0000000f
3 ffffffff ffffffff 0 0 1 fffffffe 00000001
3 ffffffff 00000002 0 0 1 00000001 fffffffe
3 80000000 00000002 0 0 1 00000001 00000000
3 fffffff0 00000010 0 0 1 0000000f ffffff00
3 ffff0000 00010000 0 0 1 0000ffff 00000000
# Partial updates reuse the other latched operand.
5 00000000 00000000 0 0 0 00000000 00000000
1 00000003 00000000 0 0 1 00000000 00030000
2 00000000 00000007 0 0 1 00000000 00000015
2 00000000 ffffffff 0 0 1 00000002 fffffffd
1 00000100 00000000 0 0 1 000000ff ffffff00
0 00000000 00000000 0 0 1 000000ff ffffff00
1 80000000 00000000 0 0 1 7fffffff 80000000
2 00000000 00000004 0 0 1 00000002 00000000
# Eight products in flight at once.
5 00000000 00000000 0 0 0 00000000 00000000
3 00000001 00000001 0 0 1 00000000 00000001
3 00000002 00000003 0 0 1 00000000 00000006
3 0000ffff 0000ffff 0 0 1 00000000 fffe0001
3 00010000 00010000 0 0 1 00000001 00000000
3 7fffffff 7fffffff 0 0 1 3fffffff 00000001
3 80000000 80000000 0 0 1 40000000 00000000
3 11111111 0000000f 0 0 1 00000000 ffffffff
3 0000000a 0000000b 0 0 1 00000000 0000006e
# Per-thread signedness, one line per slot starting at thread 0.
6 00000000 00000000 0 0 0 00000000 00000000
4 00000000 00000000 0 1 1 00000000 0000006e
3 ffffffff 00000002 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
4 00000000 00000000 5 1 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 ffffffff fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
4 00000000 00000000 0 0 1 ffffffff fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
0 00000000 00000000 0 0 1 00000001 fffffffe
